/* logic/pwo_params_pkg.sv */
/*
 * PWO parameter package
 * Arithmetic constants for the ML-DSA modulus, the memory word geometry
 * and the vector types whose widths carry a meaning in the engine.
 */

package pwo_params_pkg;

    // ======================================================================
    // Arithmetic
    // ======================================================================
    localparam int COEFF_WIDTH = 23;

    // q = 2^23 - 2^13 + 1
    localparam logic [COEFF_WIDTH-1:0] PWO_Q = 23'd8380417;

    // ======================================================================
    // Memory geometry
    // ======================================================================
    localparam int SLOT_WIDTH      = 24;
    localparam int COEFFS_PER_WORD = 4;
    localparam int POLY_WORDS      = 64;
    localparam int MEM_ADDR_WIDTH  = 15;

    // Read request to write request, in cycles
    localparam int PIPE_LATENCY = 3;

    typedef logic [COEFF_WIDTH-1:0]                 coeff_t;
    typedef logic [COEFFS_PER_WORD*SLOT_WIDTH-1:0]  mem_word_t;
    typedef logic [MEM_ADDR_WIDTH-1:0]              mem_addr_t;
    typedef logic [$clog2(POLY_WORDS)-1:0]          word_idx_t;

endpackage

/* logic/pwo_types_pkg.sv */
/*
 * PWO types package
 * Operation and memory command encodings, plus the packed memory
 * request and the per-item lane operation that rides with the data.
 */

package pwo_types_pkg;

    // Pointwise operation selected at start
    typedef enum logic [1:0] {
        PWO_PWM = 2'd0,
        PWO_PWA = 2'd1,
        PWO_PWS = 2'd2
    } pwo_mode_t;

    // Memory port command
    typedef enum logic [1:0] {
        RW_IDLE  = 2'd0,
        RW_READ  = 2'd1,
        RW_WRITE = 2'd2
    } rw_cmd_t;

    // One request toward an external memory
    typedef struct packed {
        rw_cmd_t                   cmd;
        pwo_params_pkg::mem_addr_t addr;
    } mem_req_t;

    // Travels into the lanes aligned with the returning read data
    typedef struct packed {
        logic      valid;
        pwo_mode_t mode;
        logic      use_c;
    } lane_op_t;

endpackage

/* logic/pwo_mod_mul.sv */
/*
 * Modular multiplier for q = 8380417
 * Stage one registers the full product, stage two folds the high part
 * using 2^23 = 2^13 - 1 mod q and ends with one conditional subtract.
 * Two cycles of latency, one new operand pair per cycle.
 */

`timescale 1ns/10ps

module pwo_mod_mul (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   zeroize_i,
    input  pwo_params_pkg::coeff_t a_i,
    input  pwo_params_pkg::coeff_t b_i,
    output pwo_params_pkg::coeff_t p_o
);
    import pwo_params_pkg::*;

    logic [2*COEFF_WIDTH-1:0] prod_q;
    logic [36:0]              fold1;
    logic [27:0]              fold2;
    logic [23:0]              fold3;
    coeff_t                   red;

    // Each fold maps H*2^23 + L onto H*2^13 - H + L
    assign fold1 = {1'b0, prod_q[45:23], 13'd0} + 37'(prod_q[22:0]) - 37'(prod_q[45:23]);
    assign fold2 = {1'b0, fold1[36:23], 13'd0} + 28'(fold1[22:0]) - 28'(fold1[36:23]);

    // High part is now only 5 bits wide
    assign fold3 = 24'({fold2[27:23], 13'd0}) + 24'(fold2[22:0]) - 24'(fold2[27:23]);

    // fold3 stays below 2q here
    always_comb begin
        if (fold3 >= 24'(PWO_Q)) begin
            red = coeff_t'(fold3 - 24'(PWO_Q));
        end else begin
            red = fold3[COEFF_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod_q <= '0;
            p_o    <= '0;
        end else if (zeroize_i) begin
            prod_q <= '0;
            p_o    <= '0;
        end else begin
            prod_q <= a_i * b_i;
            p_o    <= red;
        end
    end

endmodule

/* logic/pwo_lane.sv */
/*
 * PWO coefficient lane
 * Runs a multiply in parallel with a modular add or subtract, aligns
 * the two paths and picks the result by mode, adding the old C
 * coefficient for multiply-accumulate.
 */

`timescale 1ns/10ps

module pwo_lane (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    zeroize_i,
    input  pwo_types_pkg::lane_op_t op_i,
    input  pwo_params_pkg::coeff_t  a_i,
    input  pwo_params_pkg::coeff_t  b_i,
    input  pwo_params_pkg::coeff_t  c_i,
    output pwo_params_pkg::coeff_t  r_o
);
    import pwo_params_pkg::*;
    import pwo_types_pkg::*;

    function automatic coeff_t add_mod(coeff_t x, coeff_t y);
        logic [COEFF_WIDTH:0] s;
        s = {1'b0, x} + {1'b0, y};
        if (s >= {1'b0, PWO_Q}) begin
            s = s - {1'b0, PWO_Q};
        end
        return s[COEFF_WIDTH-1:0];
    endfunction

    function automatic coeff_t sub_mod(coeff_t x, coeff_t y);
        coeff_t d;
        d = x - y;
        // Wraps back into range modulo 2^23
        if (x < y) begin
            d = d + PWO_Q;
        end
        return d;
    endfunction

    lane_op_t op_q1, op_q2;
    coeff_t   addsub_d, addsub_q1, addsub_q2;
    coeff_t   c_q1, c_q2;
    coeff_t   prod, base;

    assign addsub_d = (op_i.mode == PWO_PWS) ? sub_mod(a_i, b_i) : add_mod(a_i, b_i);

    pwo_mod_mul mul0 (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .a_i       (a_i),
        .b_i       (b_i),
        .p_o       (prod)
    );

    // Two stages to match the multiplier
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            op_q1     <= '0;
            op_q2     <= '0;
            addsub_q1 <= '0;
            addsub_q2 <= '0;
            c_q1      <= '0;
            c_q2      <= '0;
        end else if (zeroize_i) begin
            op_q1     <= '0;
            op_q2     <= '0;
            addsub_q1 <= '0;
            addsub_q2 <= '0;
            c_q1      <= '0;
            c_q2      <= '0;
        end else begin
            op_q1 <= op_i;
            op_q2 <= op_q1;
            if (op_i.valid) begin
                addsub_q1 <= addsub_d;
                c_q1      <= c_i;
            end
            if (op_q1.valid) begin
                addsub_q2 <= addsub_q1;
                c_q2      <= c_q1;
            end
        end
    end

    always_comb begin
        base = (op_q2.mode == PWO_PWM) ? prod : addsub_q2;
        r_o  = op_q2.use_c ? add_mod(base, c_q2) : base;
    end

endmodule

/* logic/pwo_ctrl.sv */
/*
 * PWO controller
 * Latches the pass configuration on a start strobe, issues one read per
 * cycle to A, B and optionally C, and schedules each write exactly
 * PIPE_LATENCY cycles after its read. Signals busy and done.
 */

`timescale 1ns/10ps

module pwo_ctrl (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      zeroize_i,
    input  logic                      enable_i,
    input  pwo_types_pkg::pwo_mode_t  mode_i,
    input  logic                      accumulate_i,
    input  pwo_params_pkg::mem_addr_t a_base_i,
    input  pwo_params_pkg::mem_addr_t b_base_i,
    input  pwo_params_pkg::mem_addr_t c_base_i,
    output pwo_types_pkg::mem_req_t   a_rd_req_o,
    output pwo_types_pkg::mem_req_t   b_rd_req_o,
    output pwo_types_pkg::mem_req_t   c_rd_req_o,
    output pwo_types_pkg::mem_req_t   c_wr_req_o,
    output pwo_types_pkg::lane_op_t   lane_op_o,
    output logic                      busy_o,
    output logic                      done_o
);
    import pwo_params_pkg::*;
    import pwo_types_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_DRAIN,
        ST_DONE
    } state_t;

    state_t    state_q, state_d;
    word_idx_t idx_q;
    pwo_mode_t mode_q;
    logic      use_c_q;
    mem_addr_t a_base_q, b_base_q, c_base_q;
    mem_addr_t rd_offset;
    logic      start, rd_active, last_word;

    // Bit i marks a word whose read went out i+1 cycles ago
    // The top bit lines up with its write
    logic [PIPE_LATENCY-1:0] wr_vld_q;
    mem_addr_t               wr_addr_q [PIPE_LATENCY];

    assign start     = (state_q == ST_IDLE) && enable_i;
    assign rd_active = (state_q == ST_RUN);
    assign last_word = (idx_q == word_idx_t'(POLY_WORDS - 1));
    assign rd_offset = mem_addr_t'(idx_q);

    // ======================================================================
    // Pass sequencing
    // ======================================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:  if (enable_i) state_d = ST_RUN;
            ST_RUN:   if (last_word) state_d = ST_DRAIN;
            // Leave once only the final write remains in flight
            ST_DRAIN: begin
                if (wr_vld_q[PIPE_LATENCY-1] && (wr_vld_q[PIPE_LATENCY-2:0] == '0)) begin
                    state_d = ST_DONE;
                end
            end
            ST_DONE:  state_d = ST_IDLE;
            default:  state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q  <= ST_IDLE;
            idx_q    <= '0;
            mode_q   <= PWO_PWM;
            use_c_q  <= 1'b0;
            wr_vld_q <= '0;
        end else if (zeroize_i) begin
            state_q  <= ST_IDLE;
            idx_q    <= '0;
            mode_q   <= PWO_PWM;
            use_c_q  <= 1'b0;
            wr_vld_q <= '0;
        end else begin
            state_q  <= state_d;
            wr_vld_q <= {wr_vld_q[PIPE_LATENCY-2:0], rd_active};
            if (start) begin
                idx_q   <= '0;
                mode_q  <= mode_i;
                use_c_q <= (mode_i == PWO_PWM) && accumulate_i;
            end else if (rd_active) begin
                idx_q <= idx_q + 1'b1;
            end
        end
    end

    // Base addresses and the write address delay line
    always_ff @(posedge clk) begin
        if (start) begin
            a_base_q <= a_base_i;
            b_base_q <= b_base_i;
            c_base_q <= c_base_i;
        end
        wr_addr_q[0] <= c_base_q + rd_offset;
        for (int i = 1; i < PIPE_LATENCY; i++) begin
            wr_addr_q[i] <= wr_addr_q[i-1];
        end
    end

    // ======================================================================
    // Memory requests
    // ======================================================================
    always_comb begin
        a_rd_req_o.cmd  = rd_active ? RW_READ : RW_IDLE;
        a_rd_req_o.addr = rd_active ? a_base_q + rd_offset : '0;
        b_rd_req_o.cmd  = rd_active ? RW_READ : RW_IDLE;
        b_rd_req_o.addr = rd_active ? b_base_q + rd_offset : '0;

        // Old C word only feeds multiply-accumulate
        c_rd_req_o.cmd  = (rd_active && use_c_q) ? RW_READ : RW_IDLE;
        c_rd_req_o.addr = (rd_active && use_c_q) ? c_base_q + rd_offset : '0;

        c_wr_req_o.cmd  = wr_vld_q[PIPE_LATENCY-1] ? RW_WRITE : RW_IDLE;
        c_wr_req_o.addr = wr_vld_q[PIPE_LATENCY-1] ? wr_addr_q[PIPE_LATENCY-1] : '0;
    end

    always_comb begin
        lane_op_o.valid = wr_vld_q[0];
        lane_op_o.mode  = mode_q;
        lane_op_o.use_c = use_c_q;
    end

    assign busy_o = (state_q == ST_RUN) || (state_q == ST_DRAIN);
    assign done_o = (state_q == ST_DONE);

endmodule

/* logic/pwo_top.sv */
/*
 * PWO engine top level
 * Connects the controller to four coefficient lanes, unpacks the
 * padded memory words into lane operands and repacks the results.
 */

`timescale 1ns/10ps

module pwo_top (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      zeroize_i,
    input  logic                      enable_i,
    input  pwo_types_pkg::pwo_mode_t  mode_i,
    input  logic                      accumulate_i,
    input  pwo_params_pkg::mem_addr_t a_base_i,
    input  pwo_params_pkg::mem_addr_t b_base_i,
    input  pwo_params_pkg::mem_addr_t c_base_i,
    output pwo_types_pkg::mem_req_t   a_rd_req_o,
    output pwo_types_pkg::mem_req_t   b_rd_req_o,
    output pwo_types_pkg::mem_req_t   c_rd_req_o,
    output pwo_types_pkg::mem_req_t   c_wr_req_o,
    output pwo_params_pkg::mem_word_t c_wr_data_o,
    input  pwo_params_pkg::mem_word_t a_rd_data_i,
    input  pwo_params_pkg::mem_word_t b_rd_data_i,
    input  pwo_params_pkg::mem_word_t c_rd_data_i,
    output logic                      busy_o,
    output logic                      done_o
);
    import pwo_params_pkg::*;
    import pwo_types_pkg::*;

    lane_op_t lane_op;
    coeff_t   lane_r [COEFFS_PER_WORD];

    pwo_ctrl ctrl0 (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .enable_i     (enable_i),
        .mode_i       (mode_i),
        .accumulate_i (accumulate_i),
        .a_base_i     (a_base_i),
        .b_base_i     (b_base_i),
        .c_base_i     (c_base_i),
        .a_rd_req_o   (a_rd_req_o),
        .b_rd_req_o   (b_rd_req_o),
        .c_rd_req_o   (c_rd_req_o),
        .c_wr_req_o   (c_wr_req_o),
        .lane_op_o    (lane_op),
        .busy_o       (busy_o),
        .done_o       (done_o)
    );

    // Slot i holds coefficient i, top bit of each slot is padding
    for (genvar i = 0; i < COEFFS_PER_WORD; i++) begin : g_lane
        pwo_lane lane (
            .clk       (clk),
            .reset_n   (reset_n),
            .zeroize_i (zeroize_i),
            .op_i      (lane_op),
            .a_i       (a_rd_data_i[i*SLOT_WIDTH +: COEFF_WIDTH]),
            .b_i       (b_rd_data_i[i*SLOT_WIDTH +: COEFF_WIDTH]),
            .c_i       (c_rd_data_i[i*SLOT_WIDTH +: COEFF_WIDTH]),
            .r_o       (lane_r[i])
        );

        assign c_wr_data_o[i*SLOT_WIDTH +: SLOT_WIDTH] =
            {{(SLOT_WIDTH-COEFF_WIDTH){1'b0}}, lane_r[i]};
    end

endmodule

/* tests/pwo_top_properties.sv */
/*
 * PWO top-level timing properties
 * Write scheduling against the A reads, the done pulse width and
 * idle requests outside a pass.
 */

`timescale 1ns/10ps

module pwo_top_properties (
    input logic                    clk,
    input logic                    reset_n,
    input logic                    zeroize_i,
    input pwo_types_pkg::mem_req_t a_rd_req_o,
    input pwo_types_pkg::mem_req_t b_rd_req_o,
    input pwo_types_pkg::mem_req_t c_rd_req_o,
    input pwo_types_pkg::mem_req_t c_wr_req_o,
    input logic                    busy_o,
    input logic                    done_o
);
    import pwo_types_pkg::*;

    // Every write has its A read three cycles earlier
    write_after_read: assert property (@(posedge clk) disable iff (!reset_n)
        (c_wr_req_o.cmd == RW_WRITE) |-> ($past(a_rd_req_o.cmd, 3) == RW_READ))
        else $error("C write without an A read three cycles before");

    // Every read gets its write unless zeroize cut the pass short
    read_then_write: assert property (@(posedge clk) disable iff (!reset_n)
        (($past(a_rd_req_o.cmd, 3) == RW_READ) && !zeroize_i && !$past(zeroize_i, 1) &&
         !$past(zeroize_i, 2) && !$past(zeroize_i, 3)) |-> (c_wr_req_o.cmd == RW_WRITE))
        else $error("A read not followed by a C write after three cycles");

    done_single: assert property (@(posedge clk) disable iff (!reset_n)
        done_o |=> !done_o)
        else $error("done high for two cycles");

    idle_when_not_busy: assert property (@(posedge clk) disable iff (!reset_n)
        !busy_o |-> (a_rd_req_o.cmd == RW_IDLE && b_rd_req_o.cmd == RW_IDLE &&
                     c_rd_req_o.cmd == RW_IDLE && c_wr_req_o.cmd == RW_IDLE))
        else $error("memory request active while not busy");

endmodule

bind pwo_top pwo_top_properties props0 (
    .clk        (clk),
    .reset_n    (reset_n),
    .zeroize_i  (zeroize_i),
    .a_rd_req_o (a_rd_req_o),
    .b_rd_req_o (b_rd_req_o),
    .c_rd_req_o (c_rd_req_o),
    .c_wr_req_o (c_wr_req_o),
    .busy_o     (busy_o),
    .done_o     (done_o)
);

/* tests/pwo_top_tb.sv */
/*
 * PWO engine testbench
 * Directed tests of the pointwise multiply, multiply-accumulate, add and
 * subtract passes, base addressing, status timing, zeroize and reset.
 * Behavioral A, B and C memories answer the DUT request ports.
 */

`timescale 1ns/10ps

module pwo_top_tb;
    import pwo_params_pkg::*;
    import pwo_types_pkg::*;

    localparam int MEM_DEPTH    = 2**MEM_ADDR_WIDTH;
    localparam int RESET_CYCLES = 5;
    localparam int PASS_CYCLES  = POLY_WORDS + PIPE_LATENCY + 10;
    // Six full passes plus two aborted ones and the gaps around them
    localparam int CYCLE_LIMIT  = 8 * PASS_CYCLES + RESET_CYCLES;
    localparam longint Q_L      = longint'(PWO_Q);

    logic      clk, reset_n, zeroize, enable, accumulate;
    pwo_mode_t mode_in;
    mem_addr_t a_base, b_base, c_base;
    mem_req_t  a_rd_req, b_rd_req, c_rd_req, c_wr_req;
    mem_word_t a_rd_data, b_rd_data, c_rd_data, c_wr_data;
    logic      busy, done;

    mem_word_t mem_a [MEM_DEPTH];
    mem_word_t mem_b [MEM_DEPTH];
    mem_word_t mem_c [MEM_DEPTH];
    mem_word_t c_old [POLY_WORDS];
    mem_addr_t wr_addrs [$];

    logic [31:0] lfsr_state = 32'd30;
    int cycles = 0;
    int done_count = 0;
    int write_count = 0;
    int c_read_count = 0;
    int errors = 0;
    int checks = 0;
    int tests_run = 0;

    pwo_top dut0 (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize),
        .enable_i     (enable),
        .mode_i       (mode_in),
        .accumulate_i (accumulate),
        .a_base_i     (a_base),
        .b_base_i     (b_base),
        .c_base_i     (c_base),
        .a_rd_req_o   (a_rd_req),
        .b_rd_req_o   (b_rd_req),
        .c_rd_req_o   (c_rd_req),
        .c_wr_req_o   (c_wr_req),
        .c_wr_data_o  (c_wr_data),
        .a_rd_data_i  (a_rd_data),
        .b_rd_data_i  (b_rd_data),
        .c_rd_data_i  (c_rd_data),
        .busy_o       (busy),
        .done_o       (done)
    );

    always #50 clk = ~clk;

    // Memories with one cycle of read latency
    always @(posedge clk) begin
        if (a_rd_req.cmd == RW_READ) a_rd_data <= mem_a[a_rd_req.addr];
        if (b_rd_req.cmd == RW_READ) b_rd_data <= mem_b[b_rd_req.addr];
        if (c_rd_req.cmd == RW_READ) begin
            c_rd_data <= mem_c[c_rd_req.addr];
            c_read_count++;
        end
        if (c_wr_req.cmd == RW_WRITE) begin
            mem_c[c_wr_req.addr] <= c_wr_data;
            wr_addrs.push_back(c_wr_req.addr);
            write_count++;
        end
        if (done) done_count++;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not end within %0d cycles", CYCLE_LIMIT);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // ======================================================================
    // Stimulus and reference model
    // ======================================================================
    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic next_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic coeff_t draw_coeff();
        coeff_t v;
        for (int i = 0; i < COEFF_WIDTH; i++) begin
            v[i] = next_bit();
        end
        if (v >= PWO_Q) v = v - PWO_Q;
        return v;
    endfunction

    function automatic coeff_t slot_of(mem_word_t w, int s);
        return w[s*SLOT_WIDTH +: COEFF_WIDTH];
    endfunction

    function automatic mem_word_t c_pattern(int addr);
        mem_word_t w;
        w = '0;
        for (int s = 0; s < COEFFS_PER_WORD; s++) begin
            w[s*SLOT_WIDTH +: SLOT_WIDTH] =
                {1'b0, coeff_t'((longint'(addr * 4 + s) * 7919 + 12345) % Q_L)};
        end
        return w;
    endfunction

    function automatic coeff_t expect_coeff(pwo_mode_t m, logic acc, coeff_t a, coeff_t b,
                                            coeff_t c);
        longint r;
        case (m)
            PWO_PWM: begin
                r = (longint'(a) * longint'(b)) % Q_L;
                if (acc) r = (r + longint'(c)) % Q_L;
            end
            PWO_PWA: r = (longint'(a) + longint'(b)) % Q_L;
            default: r = (longint'(a) + Q_L - longint'(b)) % Q_L;
        endcase
        return coeff_t'(r);
    endfunction

    // Words 0 to 2 carry edge operands, including q-1 and a below b
    task automatic fill_operands(mem_addr_t ab, mem_addr_t bb);
        coeff_t a, b;
        for (int k = 0; k < POLY_WORDS; k++) begin
            mem_a[mem_addr_t'(ab + k)] = '0;
            mem_b[mem_addr_t'(bb + k)] = '0;
            for (int s = 0; s < COEFFS_PER_WORD; s++) begin
                a = draw_coeff();
                b = draw_coeff();
                if (k == 0) begin
                    a = PWO_Q - 1;
                    b = PWO_Q - 1;
                end else if (k == 1) begin
                    a = PWO_Q - 1;
                    b = coeff_t'(s + 1);
                end else if (k == 2) begin
                    a = coeff_t'(s);
                    b = PWO_Q - 1;
                end
                mem_a[mem_addr_t'(ab + k)][s*SLOT_WIDTH +: SLOT_WIDTH] = {1'b0, a};
                mem_b[mem_addr_t'(bb + k)][s*SLOT_WIDTH +: SLOT_WIDTH] = {1'b0, b};
            end
        end
    endtask

    // ======================================================================
    // Compare tasks
    // ======================================================================
    task automatic compare_word(mem_word_t got, mem_word_t exp, string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic compare_addr(mem_addr_t got, mem_addr_t exp, string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, msg, got, exp);
        end
    endtask

    task automatic compare_flag(bit got, bit exp, string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %0b expected %0b", $time, msg, got, exp);
        end
    endtask

    task automatic report_test(string name, int errors_before);
        tests_run++;
        $display("%s: %s", name, (errors == errors_before) ? "ok" : "errors");
    endtask

    task automatic check_pass(pwo_mode_t m, logic acc, mem_addr_t ab, mem_addr_t bb,
                              mem_addr_t cb);
        mem_word_t exp;
        for (int k = 0; k < POLY_WORDS; k++) begin
            exp = '0;
            for (int s = 0; s < COEFFS_PER_WORD; s++) begin
                exp[s*SLOT_WIDTH +: SLOT_WIDTH] = {1'b0, expect_coeff(m, acc,
                    slot_of(mem_a[mem_addr_t'(ab + k)], s),
                    slot_of(mem_b[mem_addr_t'(bb + k)], s), slot_of(c_old[k], s))};
            end
            compare_word(mem_c[mem_addr_t'(cb + k)], exp, $sformatf("C word %0d", k));
        end
    endtask

    // One full pass, optionally with a stray strobe while busy
    task automatic run_pass(pwo_mode_t m, logic acc, mem_addr_t ab, mem_addr_t bb,
                            mem_addr_t cb, bit extra_strobe);
        int d0;
        int r0;
        for (int k = 0; k < POLY_WORDS; k++) begin
            c_old[k] = mem_c[mem_addr_t'(cb + k)];
        end
        wr_addrs.delete();
        d0 = done_count;
        r0 = c_read_count;
        @(negedge clk);
        mode_in    = m;
        accumulate = acc;
        a_base     = ab;
        b_base     = bb;
        c_base     = cb;
        enable     = 1'b1;
        @(negedge clk);
        enable = 1'b0;
        compare_flag(busy, 1'b1, "busy after start");
        if (extra_strobe) begin
            repeat (10) @(negedge clk);
            mode_in = PWO_PWA;
            enable  = 1'b1;
            @(negedge clk);
            enable = 1'b0;
        end
        while (done_count == d0) @(negedge clk);
        repeat (3) @(negedge clk);
        compare_flag(done_count == d0 + 1, 1'b1, "single done pulse");
        compare_flag(busy, 1'b0, "busy after pass");
        // Old C words are fetched only for multiply-accumulate
        compare_flag(c_read_count - r0 == ((m == PWO_PWM && acc) ? POLY_WORDS : 0), 1'b1,
                     "C read count");
        check_pass(m, acc, ab, bb, cb);
    endtask

    // ======================================================================
    // Tests
    // ======================================================================
    task automatic pwm_product();
        int e0;
        e0 = errors;
        fill_operands(0, 64);
        run_pass(PWO_PWM, 1'b0, 0, 64, 128, 1'b0);
        report_test("pwm", e0);
    endtask

    task automatic pwm_accumulate();
        int e0;
        e0 = errors;
        run_pass(PWO_PWM, 1'b1, 0, 64, 256, 1'b0);
        report_test("pwm accumulate", e0);
    endtask

    task automatic add_and_subtract();
        int e0;
        e0 = errors;
        run_pass(PWO_PWA, 1'b0, 0, 64, 384, 1'b0);
        run_pass(PWO_PWS, 1'b0, 0, 64, 448, 1'b0);
        report_test("pwa and pws", e0);
    endtask

    task automatic base_addressing();
        int e0;
        e0 = errors;
        fill_operands(3000, 7000);
        run_pass(PWO_PWM, 1'b0, 3000, 7000, 20000, 1'b0);
        compare_flag(wr_addrs.size() == POLY_WORDS, 1'b1, "write count");
        foreach (wr_addrs[k]) begin
            compare_addr(wr_addrs[k], mem_addr_t'(20000 + k), "write address");
        end
        // Neighbors on both sides stay untouched
        for (int k = 1; k <= POLY_WORDS; k++) begin
            compare_word(mem_c[20000 - k], c_pattern(20000 - k), "C word below range");
            compare_word(mem_c[20063 + k], c_pattern(20063 + k), "C word above range");
        end
        report_test("base addresses", e0);
    endtask

    task automatic status_flags();
        int e0;
        e0 = errors;
        run_pass(PWO_PWM, 1'b0, 3000, 7000, 512, 1'b1);
        report_test("status", e0);
    endtask

    task automatic zeroize_and_reset();
        int e0, writes, d0;
        e0 = errors;
        d0 = done_count;
        @(negedge clk);
        mode_in = PWO_PWM;
        c_base  = 600;
        enable  = 1'b1;
        @(negedge clk);
        enable = 1'b0;
        repeat (20) @(negedge clk);
        compare_flag(busy, 1'b1, "busy before zeroize");
        zeroize = 1'b1;
        @(negedge clk);
        zeroize = 1'b0;
        compare_flag(busy, 1'b0, "busy after zeroize");
        writes = write_count;
        repeat (10) @(negedge clk);
        compare_flag(write_count == writes, 1'b1, "no writes after zeroize");
        compare_flag(done_count == d0, 1'b1, "no done after zeroize");

        enable = 1'b1;
        @(negedge clk);
        enable = 1'b0;
        repeat (10) @(negedge clk);
        reset_n = 1'b0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            compare_flag(a_rd_req.cmd == RW_IDLE && b_rd_req.cmd == RW_IDLE &&
                         c_rd_req.cmd == RW_IDLE && c_wr_req.cmd == RW_IDLE,
                         1'b1, "requests idle in reset");
            compare_flag(done, 1'b0, "done in reset");
        end
        reset_n = 1'b1;
        @(negedge clk);
        compare_flag(c_wr_req.cmd == RW_IDLE, 1'b1, "write idle after reset");
        compare_flag(busy, 1'b0, "busy after reset");
        report_test("zeroize and reset", e0);
    endtask

    initial begin
        clk        = 1'b0;
        reset_n    = 1'b0;
        zeroize    = 1'b0;
        enable     = 1'b0;
        accumulate = 1'b0;
        mode_in    = PWO_PWM;
        a_base     = '0;
        b_base     = '0;
        c_base     = '0;
        a_rd_data  = '0;
        b_rd_data  = '0;
        c_rd_data  = '0;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            mem_a[i] = '0;
            mem_b[i] = '0;
            mem_c[i] = c_pattern(i);
        end
        repeat (RESET_CYCLES) @(negedge clk);
        reset_n = 1'b1;

        pwm_product();
        pwm_accumulate();
        add_and_subtract();
        base_addressing();
        status_flags();
        zeroize_and_reset();

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* pwo_top.f */
logic/pwo_params_pkg.sv
logic/pwo_types_pkg.sv
logic/pwo_mod_mul.sv
logic/pwo_lane.sv
logic/pwo_ctrl.sv
logic/pwo_top.sv
tests/pwo_top_properties.sv
tests/pwo_top_tb.sv

/* Makefile */
# Verilator flow for the PWO engine

VERILATOR ?= verilator
TOP       ?= pwo_top_tb
FILELIST  ?= pwo_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  := Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
